//--- dc_pkg.sv
// Geometry assumes 32-bit words and a 4 KB backing memory; address bits above 11 are ignored
package dc_pkg;

  // Cache and memory geometry
  localparam int LINES          = 16;
  localparam int WORDS_PER_LINE = 4;
  localparam int MEM_WORDS      = 1024;
  localparam int IDX_W          = $clog2(LINES);
  localparam int OFF_W          = $clog2(WORDS_PER_LINE);
  localparam int TAG_W          = 4;                     // Address bits 11:8
  localparam int MEM_AW         = $clog2(MEM_WORDS);

  // Bit 0 store, bits 2:1 size, bit 3 unsigned
  typedef enum logic [3:0] {
    OP_LB  = 4'b0000,
    OP_SB  = 4'b0001,
    OP_LH  = 4'b0010,
    OP_SH  = 4'b0011,
    OP_LW  = 4'b0100,
    OP_SW  = 4'b0101,
    OP_LBU = 4'b1000,
    OP_LHU = 4'b1010
  } dc_op_e;

  typedef struct packed {
    dc_op_e      op;
    logic [31:0] addr;
    logic [3:0]  lsqid;
    logic [31:0] wdata;
  } dc_req_t;

  typedef struct packed {
    logic        valid;
    logic        error;  // Misaligned access
    logic [3:0]  lsqid;
    logic [31:0] rdata;
  } dc_resp_t;

  typedef struct packed {
    logic              we;
    logic [MEM_AW-1:0] addr;  // Word address
    logic [3:0]        be;
    logic [31:0]       wdata;
  } mem_req_t;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_LOOKUP,
    ST_REFILL,
    ST_RESP
  } ctrl_state_e;

endpackage

//--- dc_lane.sv
// Purely combinational; little-endian lanes, only SB/SH/SW and the five load ops are decoded
`timescale 1ns/10ps

module dc_lane (
  input  dc_pkg::dc_req_t req,
  input  logic [31:0]     word,
  output logic            misaligned,
  output logic [3:0]      be,
  output logic [31:0]     wdata,
  output logic [31:0]     rdata
);

  logic [1:0]  size;
  logic [7:0]  byte_sel;
  logic [15:0] half_sel;

  assign size = req.op[2:1];

  // Half needs bit 0 clear, word needs both low bits clear
  assign misaligned = (size == 2'b01 && req.addr[0]) ||
                      (size == 2'b10 && req.addr[1:0] != 2'b00);

  assign byte_sel = 8'(word >> {req.addr[1:0], 3'b000});
  assign half_sel = 16'(word >> {req.addr[1], 4'b0000});

  always_comb begin
    be    = 4'b0000;
    wdata = req.wdata;
    rdata = word;   // LW passes the word through
    case (req.op)
      dc_pkg::OP_SB: begin
        be    = 4'b0001 << req.addr[1:0];
        wdata = req.wdata << {req.addr[1:0], 3'b000};
      end
      dc_pkg::OP_SH: begin
        be    = 4'b0011 << {req.addr[1], 1'b0};
        wdata = req.wdata << {req.addr[1], 4'b0000};
      end
      dc_pkg::OP_SW: be = 4'b1111;
      dc_pkg::OP_LB:  rdata = {{24{byte_sel[7]}}, byte_sel};
      dc_pkg::OP_LBU: rdata = {24'd0, byte_sel};
      dc_pkg::OP_LH:  rdata = {{16{half_sel[15]}}, half_sel};
      dc_pkg::OP_LHU: rdata = {16'd0, half_sel};
      default: ;
    endcase
  end

endmodule

//--- dc_array.sv
// Direct-mapped storage; a refill beat takes priority over a store merge in the same cycle
`timescale 1ns/10ps

module dc_array (
  input  logic                      clk,
  input  logic                      rst,
  input  logic [dc_pkg::IDX_W-1:0]  idx,
  input  logic [dc_pkg::TAG_W-1:0]  tag,
  output logic                      hit,
  input  logic [dc_pkg::OFF_W-1:0]  rd_word_off,
  output logic [31:0]               rd_word,
  input  logic                      wr_en,
  input  logic [3:0]                wr_be,
  input  logic [31:0]               wr_data,
  input  logic                      fill_en,
  input  logic [dc_pkg::OFF_W-1:0]  fill_off,
  input  logic [31:0]               fill_data,
  input  logic                      fill_done
);

  logic [31:0]              data [dc_pkg::LINES * dc_pkg::WORDS_PER_LINE];
  logic [dc_pkg::TAG_W-1:0] tags [dc_pkg::LINES];
  logic [dc_pkg::LINES-1:0] valid;

  assign hit     = valid[idx] && (tags[idx] == tag);
  assign rd_word = data[{idx, rd_word_off}];

  always_ff @(posedge clk) begin
    if (rst) begin
      valid <= '0;
    end else if (fill_done) begin
      valid[idx] <= 1'b1;  // Line usable once the last beat lands
    end
  end

  always_ff @(posedge clk) begin
    if (fill_en) begin
      data[{idx, fill_off}] <= fill_data;
    end else if (wr_en) begin
      for (int b = 0; b < 4; b++) begin
        if (wr_be[b]) data[{idx, rd_word_off}][8*b +: 8] <= wr_data[8*b +: 8];
      end
    end
    if (fill_done) tags[idx] <= tag;
  end

endmodule

//--- dc_refill_cnt.sv
// Two cycles per beat (issue then capture), one line per start; a start while busy restarts it
`timescale 1ns/10ps

module dc_refill_cnt (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      start,
  output logic [dc_pkg::OFF_W-1:0]  beat,
  output logic                      capture,
  output logic                      last
);

  logic active;
  logic phase;  // 0 issue, 1 capture

  assign capture = active && phase;
  assign last    = capture && (beat == dc_pkg::OFF_W'(dc_pkg::WORDS_PER_LINE - 1));

  always_ff @(posedge clk) begin
    if (rst) begin
      active <= 1'b0;
      phase  <= 1'b0;
      beat   <= '0;
    end else if (start) begin
      active <= 1'b1;
      phase  <= 1'b0;
      beat   <= '0;
    end else if (active) begin
      phase <= ~phase;
      if (phase) begin
        beat <= beat + 1'b1;             // Wraps back to zero after the last beat
        if (last) active <= 1'b0;
      end
    end
  end

endmodule

//--- dc_ctrl.sv
// One request at a time; responses are registered, and loads dropped by flush still finish refills
`timescale 1ns/10ps

module dc_ctrl (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      lsq_dc_req,
  input  logic                      lsq_dc_flush,
  input  dc_pkg::dc_req_t           lsq_dc,
  output logic                      ready,
  output dc_pkg::dc_req_t           cur,
  input  logic                      hit,
  input  logic                      misaligned,
  input  logic [3:0]                lane_be,
  input  logic [31:0]               lane_wdata,
  input  logic [31:0]               lane_rdata,
  output logic                      arr_wr_en,
  output logic                      fill_en,
  output logic                      fill_done,
  output logic                      refill_start,
  input  logic [dc_pkg::OFF_W-1:0]  beat,
  input  logic                      capture,
  input  logic                      last,
  output dc_pkg::mem_req_t          mem,
  output dc_pkg::dc_resp_t          resp
);

  dc_pkg::ctrl_state_e state;
  logic        accept;
  logic        cur_store;
  logic        lookup;
  logic        kill;       // Pending load response dropped by flush
  logic        resp_valid;
  logic        resp_error;
  logic [3:0]  resp_lsqid;
  logic [31:0] resp_rdata;

  assign ready     = (state == dc_pkg::ST_IDLE);
  assign accept    = lsq_dc_req && (lsq_dc.op[0] || !lsq_dc_flush);  // Stores survive flush
  assign cur_store = cur.op[0];
  assign lookup    = (state == dc_pkg::ST_LOOKUP);

  assign arr_wr_en    = lookup && cur_store && !misaligned && hit;
  assign refill_start = lookup && !cur_store && !misaligned && !hit;
  assign fill_en      = (state == dc_pkg::ST_REFILL) && capture;
  assign fill_done    = (state == dc_pkg::ST_REFILL) && last;

  always_comb begin
    mem.we    = lookup && cur_store && !misaligned;  // Write-through
    mem.addr  = cur.addr[dc_pkg::MEM_AW+1:2];
    mem.be    = lane_be;
    mem.wdata = lane_wdata;
    if (state == dc_pkg::ST_REFILL) begin
      mem.addr = {cur.addr[dc_pkg::MEM_AW+1:dc_pkg::OFF_W+2], beat};
    end
  end

  always_ff @(posedge clk) begin
    if (ready && accept) cur <= lsq_dc;
    if (lookup || state == dc_pkg::ST_RESP) begin
      resp_lsqid <= cur.lsqid;
      resp_rdata <= misaligned ? 32'd0 : lane_rdata;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= dc_pkg::ST_IDLE;
      kill       <= 1'b0;
      resp_valid <= 1'b0;
      resp_error <= 1'b0;
    end else begin
      resp_valid <= 1'b0;
      resp_error <= 1'b0;
      case (state)
        dc_pkg::ST_IDLE: if (accept) state <= dc_pkg::ST_LOOKUP;
        dc_pkg::ST_LOOKUP: begin
          kill <= lsq_dc_flush;
          if (misaligned) begin
            resp_valid <= cur_store || !lsq_dc_flush;
            resp_error <= cur_store || !lsq_dc_flush;
            state      <= dc_pkg::ST_IDLE;
          end else if (cur_store) begin
            state <= dc_pkg::ST_IDLE;
          end else if (hit) begin
            resp_valid <= !lsq_dc_flush;
            state      <= dc_pkg::ST_IDLE;
          end else begin
            state <= dc_pkg::ST_REFILL;
          end
        end
        dc_pkg::ST_REFILL: begin
          kill <= kill || lsq_dc_flush;
          if (last) state <= dc_pkg::ST_RESP;
        end
        dc_pkg::ST_RESP: begin
          resp_valid <= !(kill || lsq_dc_flush);
          state      <= dc_pkg::ST_IDLE;
        end
        default: state <= dc_pkg::ST_IDLE;
      endcase
    end
  end

  assign resp = '{valid: resp_valid, error: resp_error, lsqid: resp_lsqid, rdata: resp_rdata};

endmodule

//--- dc_mem.sv
// Contents start at zero and survive reset; read during a write to the same word returns old data
`timescale 1ns/10ps

module dc_mem (
  input  logic              clk,
  input  dc_pkg::mem_req_t  req,
  output logic [31:0]       rdata
);

  logic [31:0] words [dc_pkg::MEM_WORDS] = '{default: '0};

  always_ff @(posedge clk) begin
    if (req.we) begin
      for (int b = 0; b < 4; b++) begin
        if (req.be[b]) words[req.addr][8*b +: 8] <= req.wdata[8*b +: 8];
      end
    end
    rdata <= words[req.addr];  // Read every cycle
  end

endmodule

//--- dc_top.sv
// Blocking write-through cache; hold lsq_dc_req until dcache_ready and take every response at once
`timescale 1ns/10ps

module dc_top (
  input  logic             clk,
  input  logic             rst,
  input  logic             lsq_dc_req,
  input  logic             lsq_dc_flush,
  input  dc_pkg::dc_req_t  lsq_dc,
  output logic             dcache_ready,
  output dc_pkg::dc_resp_t dcache
);

  dc_pkg::dc_req_t           cur;
  dc_pkg::mem_req_t          mem_req;
  logic [31:0]               mem_rdata;
  logic                      hit;
  logic [31:0]               arr_word;
  logic                      misaligned;
  logic [3:0]                lane_be;
  logic [31:0]               lane_wdata;
  logic [31:0]               lane_rdata;
  logic                      arr_wr_en;
  logic                      fill_en;
  logic                      fill_done;
  logic                      refill_start;
  logic [dc_pkg::OFF_W-1:0]  beat;
  logic                      capture;
  logic                      last;

  dc_ctrl i_ctrl (
    .clk, .rst, .lsq_dc_req, .lsq_dc_flush, .lsq_dc,
    .ready(dcache_ready), .cur, .hit, .misaligned,
    .lane_be, .lane_wdata, .lane_rdata,
    .arr_wr_en, .fill_en, .fill_done, .refill_start,
    .beat, .capture, .last, .mem(mem_req), .resp(dcache)
  );

  dc_refill_cnt i_refill_cnt (.clk, .rst, .start(refill_start), .beat, .capture, .last);

  // Index, tag and offset all come from the registered request
  dc_array i_array (
    .clk, .rst,
    .idx(cur.addr[dc_pkg::IDX_W+dc_pkg::OFF_W+1:dc_pkg::OFF_W+2]),
    .tag(cur.addr[dc_pkg::MEM_AW+1:dc_pkg::IDX_W+dc_pkg::OFF_W+2]),
    .hit, .rd_word_off(cur.addr[dc_pkg::OFF_W+1:2]), .rd_word(arr_word),
    .wr_en(arr_wr_en), .wr_be(lane_be), .wr_data(lane_wdata),
    .fill_en, .fill_off(beat), .fill_data(mem_rdata), .fill_done
  );

  dc_lane i_lane (
    .req(cur), .word(arr_word), .misaligned,
    .be(lane_be), .wdata(lane_wdata), .rdata(lane_rdata)
  );

  dc_mem i_mem (.clk, .req(mem_req), .rdata(mem_rdata));

endmodule

//--- dc_checker.sv
// Samples on the falling edge; expected latencies assume a 2-cycle lookup and 2-cycle refill beats
`timescale 1ns/10ps

module dc_checker (
  input  logic             clk,
  input  logic             rst,
  input  logic             lsq_dc_req,
  input  logic             lsq_dc_flush,
  input  dc_pkg::dc_req_t  lsq_dc,
  input  logic             dcache_ready,
  input  dc_pkg::dc_resp_t dcache,
  output int               mismatches,
  output int               failures,
  output logic             busy
);

  localparam int HIT_LAT  = 2;
  localparam int MISS_LAT = 3 + 2 * dc_pkg::WORDS_PER_LINE;  // Lookup, beats, response
  localparam int TIMEOUT  = 64;

  logic [31:0]              model [dc_pkg::MEM_WORDS] = '{default: '0};
  logic [3:0]               line_tag [dc_pkg::LINES];
  logic [dc_pkg::LINES-1:0] line_valid = '0;
  dc_pkg::dc_req_t          pend;
  logic                     pend_resp;
  logic                     pend_err;
  logic                     pend_kill;
  logic [31:0]              pend_data;
  int                       age;
  int                       lat;
  int                       mismatch_cnt = 0;
  int                       fail_cnt = 0;
  logic                     busy_q = 1'b0;

  assign mismatches = mismatch_cnt;
  assign failures   = fail_cnt;
  assign busy       = busy_q;

  task automatic report_failure(input string msg);
    fail_cnt++;
    $display("error at %0t ns: %s", $time, msg);
  endtask

  // Little-endian byte and halfword pick, then extension by op
  function automatic logic [31:0] load_value(input dc_pkg::dc_op_e op, input logic [31:0] word,
                                             input int boff);
    logic [7:0]  b;
    logic [15:0] h;
    b = word[8*boff +: 8];
    h = word[16*(boff/2) +: 16];
    case (op)
      dc_pkg::OP_LB:  return 32'($signed(b));
      dc_pkg::OP_LBU: return 32'(b);
      dc_pkg::OP_LH:  return 32'($signed(h));
      dc_pkg::OP_LHU: return 32'(h);
      default:        return word;
    endcase
  endfunction

  task automatic accept_request();
    int         size_b;
    int         boff;
    logic [9:0] w;
    logic [3:0] line;
    size_b = 1 << lsq_dc.op[2:1];
    boff   = int'(lsq_dc.addr[1:0]);
    w      = lsq_dc.addr[11:2];
    line   = lsq_dc.addr[7:4];
    if (!lsq_dc.op[0] && lsq_dc_flush) return;  // Load dropped at the door
    busy_q    = 1'b1;
    pend      = lsq_dc;
    age       = 0;
    lat       = HIT_LAT;
    pend_kill = 1'b0;
    pend_err  = (boff % size_b) != 0;
    pend_resp = pend_err || !lsq_dc.op[0];
    pend_data = '0;
    if (pend_err) return;
    if (lsq_dc.op[0]) begin
      for (int k = 0; k < size_b; k++) begin
        model[w][8*(boff+k) +: 8] = lsq_dc.wdata[8*k +: 8];
      end
    end else begin
      pend_data = load_value(lsq_dc.op, model[w], boff);
      if (!(line_valid[line] && line_tag[line] == lsq_dc.addr[11:8])) begin
        lat              = MISS_LAT;  // Line gets filled even if the load is killed
        line_valid[line] = 1'b1;
        line_tag[line]   = lsq_dc.addr[11:8];
      end
    end
  endtask

  task automatic track_request();
    logic expect_resp;
    age++;
    expect_resp = pend_resp && !pend_kill;
    if (age < lat) begin
      if (dcache.valid) report_failure("response arrived before its expected cycle");
      if (dcache_ready) report_failure("dcache_ready rose before the request finished");
      if (lsq_dc_flush && !pend.op[0]) pend_kill = 1'b1;
    end else if (!dcache_ready) begin
      if (age == lat) report_failure("dcache_ready still low when the request should finish");
      if (age >= TIMEOUT) begin
        report_failure("response timeout, the request never finished");
        busy_q = 1'b0;
      end
    end else begin
      busy_q = 1'b0;
      if (age > lat) return;  // Late finish was already counted
      if (dcache.valid !== expect_resp) begin
        if (expect_resp) report_failure("missing response for a pending request");
        else report_failure("unexpected response for a flushed load or a store");
      end else if (expect_resp && (dcache.error !== pend_err || dcache.lsqid !== pend.lsqid ||
                                   dcache.rdata !== pend_data)) begin
        mismatch_cnt++;
        $display("mismatch at %0t ns: lsqid %0d error %0b rdata %h, expected %0d %0b %h",
                 $time, dcache.lsqid, dcache.error, dcache.rdata,
                 pend.lsqid, pend_err, pend_data);
      end
    end
  endtask

  always @(negedge clk) begin
    if (rst) begin
      line_valid = '0;
      busy_q     = 1'b0;
    end else begin
      if (busy_q) begin
        track_request();
      end else begin
        if (dcache.valid || dcache.error) report_failure("response with no request in progress");
        if (!dcache_ready) report_failure("dcache_ready low with no request in progress");
      end
      if (!busy_q && dcache_ready && lsq_dc_req) accept_request();
    end
  end

endmodule

//--- tb_dc.sv
// Random requests over 64 words (4 tags on 4 lines); a ready timeout ends the run early
`timescale 1ns/10ps

module tb_dc;

  localparam int NUM_REQ       = 2000;
  localparam int READY_TIMEOUT = 100;

  logic             clk;
  logic             rst;
  logic             lsq_dc_req;
  logic             lsq_dc_flush;
  dc_pkg::dc_req_t  lsq_dc;
  logic             dcache_ready;
  dc_pkg::dc_resp_t dcache;
  logic [31:0]      seed = 32'h5564cb05;
  int               mismatches;
  int               failures;
  int               timeouts = 0;
  logic             checker_busy;
  logic             ok = 1'b1;

  dc_top i_dut (.clk, .rst, .lsq_dc_req, .lsq_dc_flush, .lsq_dc, .dcache_ready, .dcache);

  dc_checker i_checker (
    .clk, .rst, .lsq_dc_req, .lsq_dc_flush, .lsq_dc, .dcache_ready, .dcache,
    .mismatches, .failures, .busy(checker_busy)
  );

  always #20 clk = ~clk;

  function automatic logic [31:0] xorshift_next();
    seed = seed ^ (seed << 13);
    seed = seed ^ (seed >> 17);
    seed = seed ^ (seed << 5);
    return seed;
  endfunction

  function automatic logic flush_pulse();
    logic [31:0] r;
    r = xorshift_next();
    return r[4:0] == 5'd0;  // About one cycle in 32
  endfunction

  task automatic wait_ready();
    int cycles;
    cycles = 0;
    while (!dcache_ready && cycles < READY_TIMEOUT) begin
      @(posedge clk);
      #1;
      lsq_dc_flush = flush_pulse();
      cycles++;
    end
    if (!dcache_ready) begin
      timeouts++;
      ok = 1'b0;
      $display("error at %0t ns: dcache_ready stayed low for %0d cycles", $time, cycles);
    end
  endtask

  task automatic wait_checker();
    int cycles;
    cycles       = 0;
    lsq_dc_flush = 1'b0;
    while (checker_busy && cycles < READY_TIMEOUT) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (checker_busy) begin
      timeouts++;
      ok = 1'b0;
      $display("error at %0t ns: checker still waiting on a request at end of run", $time);
    end
  endtask

  task automatic send_request();
    dc_pkg::dc_req_t req;
    logic [31:0]     r;
    logic [31:0]     a;
    logic [1:0]      low;
    r = xorshift_next();
    a = xorshift_next();
    // Selects 6 and 7 map onto LBU and LHU
    req.op    = dc_pkg::dc_op_e'(r[2:1] == 2'b11 ? {2'b10, r[0], 1'b0} : {1'b0, r[2:0]});
    req.lsqid = r[7:4];
    req.wdata = xorshift_next();
    case (req.op[2:1])
      2'b00:   low = a[1:0];
      2'b01:   low = {a[1], 1'b0};
      default: low = 2'b00;
    endcase
    if (r[12:9] == 4'd0) low = a[1:0];  // Rare, often misaligned
    req.addr = {a[31:12], 2'b00, a[9:8], 2'b00, a[5:2], low};  // Bits above 11 are noise
    lsq_dc_req   = 1'b1;
    lsq_dc       = req;
    lsq_dc_flush = flush_pulse();
    @(posedge clk);
    #1;
    lsq_dc_req   = 1'b0;
    lsq_dc_flush = flush_pulse();
  endtask

  initial begin
    clk          = 1'b0;
    rst          = 1'b1;
    lsq_dc_req   = 1'b0;
    lsq_dc_flush = 1'b0;
    lsq_dc       = '0;
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;
    for (int n = 0; n < NUM_REQ && ok; n++) begin
      wait_ready();
      if (ok && xorshift_next() % 8 == 0) begin
        @(posedge clk);  // Idle gap
        #1;
        lsq_dc_flush = flush_pulse();
      end
      if (ok) send_request();
    end
    if (ok) wait_ready();
    if (ok) wait_checker();
    $display("errors: %0d mismatches, %0d failures, %0d timeouts",
             mismatches, failures, timeouts);
    if (ok && mismatches == 0 && failures == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- sim.f
dc_pkg.sv
dc_lane.sv
dc_array.sv
dc_refill_cnt.sv
dc_ctrl.sv
dc_mem.sv
dc_top.sv
dc_checker.sv
tb_dc.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_dc
RTL_TOP    := dc_top
FILELIST   := sim.f
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
